// ==== Makefile ====
TOP := armControllerTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f vlog.f

run: compile
	./obj_dir/V$(TOP) > run.log 2>&1 || true
	cat run.log
	@if grep -q "TB FAILED" run.log; then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TB PASSED" run.log; then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir run.log

// ==== bench/armControllerTb.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "armCtrl_settings.svh"

module armControllerTb;
  import armCtrlPkg::*;

  localparam int NUM_INSTRS = 500;
  localparam int MAX_CYCLES = NUM_INSTRS + NUM_INSTRS / 5;  // Reset and margin on top

  logic clk;
  logic rst;
  logic [`ARMCTRL_INSTR_W-1:0] instrD;
  flagsT  flagsE;
  logic   stallE, stallM, stallW, flushE, flushW;
  regSrcT regSrcD;
  immSrcT immSrcD;
  aluOpT  aluOpE;
  logic   aluSrcE, invertBE, reverseInputsE, aluCarryE, branchTakenE, memtoRegE;
  logic   memWriteM, regWriteM, memtoRegM, memtoRegW, regWriteW, pcSrcW, pcWrPendingF;

  // Model pipeline registers and flags
  logic       mAluSrcE, mAluInstrE, mBranchE, mMemWriteE, mRegWriteE, mMemtoRegE, mPcSrcE;
  logic [3:0] mAluCtrlE;
  logic [3:0] mCondE;
  logic [1:0] mFlagWriteE;
  logic       mMemWriteM, mRegWriteM, mMemtoRegM, mPcSrcM;
  logic       mMemtoRegW, mRegWriteW, mPcSrcW;
  flagsT      mFlags;

  // Model outputs of Decode and Execute
  regSrcT     dRegSrc;
  immSrcT     dImmSrc;
  logic       dAluSrc, dAluInstr, dBranch, dMemWrite, dRegWrite, dMemtoReg, dPcSrc;
  logic [3:0] dAluCtrl;
  logic [1:0] dFlagWrite;
  aluOpT      xAluOp;
  flagsT      xNextFlags;
  logic       xCondEx, xInvB, xRev, xCarry, xNoWrite, xPending;
  logic       xBranchTaken, xMemWrite, xRegWrite, xPcSrc;

  int checkCount;
  int errorCount;
  int cycleCount;

  clockGen clkGen (.clk, .rst);

  armController UUT (
    .clk, .rst, .instrD, .flagsE, .stallE, .stallM, .stallW, .flushE, .flushW,
    .regSrcD, .immSrcD, .aluSrcE, .aluOpE, .invertBE, .reverseInputsE, .aluCarryE,
    .branchTakenE, .memtoRegE, .memWriteM, .regWriteM, .memtoRegM, .memtoRegW,
    .regWriteW, .pcSrcW, .pcWrPendingF
  );

  // ARM pairs each condition with its inverse in bit 0
  function automatic logic condPasses(input logic [3:0] cond, input flagsT f);
    logic base;
    case (cond[3:1])
      3'd0:    base = f.z;
      3'd1:    base = f.c;
      3'd2:    base = f.n;
      3'd3:    base = f.v;
      3'd4:    base = f.c && !f.z;               // HI
      3'd5:    base = (f.n == f.v);              // GE
      3'd6:    base = !f.z && (f.n == f.v);      // GT
      default: base = 1'b1;
    endcase
    if (cond == 4'hF) return 1'b0;
    return base ^ cond[0];
  endfunction

  function automatic aluOpT expectedAluOp(input logic isDp, input logic [3:0] opc);
    if (!isDp) begin
      if (opc == 4'b0010) return aluSub;  // Load or store with U clear
      return aluAdd;
    end
    case (opc)
      4'b0000, 4'b1000: return aluAnd;            // AND, TST
      4'b0001, 4'b1001: return aluXor;            // EOR, TEQ
      4'b0100, 4'b0101, 4'b1011: return aluAdd;   // ADD, ADC, CMN
      4'b1100: return aluOr;
      4'b1101, 4'b1111: return aluPassB;          // MOV, MVN
      4'b1110: return aluBic;
      default: return aluSub;
    endcase
  endfunction

  function automatic logic [31:0] randomInstr();
    logic [31:0] fields;
    logic [31:0] pick;
    logic [31:0] condRaw;
    logic [3:0]  cond;
    fields  = $urandom;
    pick    = $urandom % 3;
    condRaw = $urandom % 15;
    cond    = (fields[31:30] == 2'b00) ? `ARMCTRL_COND_AL : condRaw[3:0];
    if (pick == 0) return {cond, 2'b00, fields[25:0]};
    if (pick == 1) return {cond, 2'b01, 1'b0, 1'b1, fields[23], 2'b00, fields[20:0]};
    return {cond, 3'b101, 1'b0, fields[23:0]};  // B
  endfunction

  task automatic evalModel();
    logic isDp, isMem, isBr, isLoad, arith;
    isDp   = (instrD[27:26] == 2'b00);
    isMem  = (instrD[27:26] == 2'b01);
    isBr   = (instrD[27:26] == 2'b10);
    isLoad = isMem && instrD[20];
    if (isBr) dRegSrc = regSrcBranch;
    else if (isMem && !isLoad) dRegSrc = regSrcStore;
    else dRegSrc = regSrcNormal;
    if (isBr) dImmSrc = immBranch;
    else if (isMem) dImmSrc = immMem;
    else dImmSrc = immDp;
    dAluSrc    = isDp ? instrD[25] : (isMem || isBr);
    dAluCtrl   = isDp ? instrD[24:21] : ((isMem && !instrD[23]) ? 4'b0010 : 4'b0100);
    dAluInstr  = isDp;
    dFlagWrite = {2{isDp && instrD[20]}};
    dBranch    = isBr;
    dMemWrite  = isMem && !isLoad;
    dRegWrite  = isDp || isLoad;
    dMemtoReg  = isLoad;
    dPcSrc     = (dRegWrite && instrD[15:12] == `ARMCTRL_PC_REG) || isBr;

    xCondEx  = condPasses(mCondE, mFlags);
    xAluOp   = expectedAluOp(mAluInstrE, mAluCtrlE);
    arith    = (xAluOp == aluAdd) || (xAluOp == aluSub);
    xInvB    = mAluInstrE && mAluCtrlE[3:1] == 3'b111;                 // BIC, MVN
    xRev     = mAluInstrE && !mAluCtrlE[3] && mAluCtrlE[1:0] == 2'b11;  // RSB, RSC
    xCarry   = mAluInstrE && mAluCtrlE[3:2] == 2'b01 && mAluCtrlE[1:0] != 2'b00
               && mFlags.c;                                            // ADC, SBC, RSC
    xNoWrite = mAluInstrE && mAluCtrlE[3:2] == 2'b10;                  // Compares

    xNextFlags = mFlags;
    if (xCondEx && mFlagWriteE[1]) begin
      xNextFlags.n = flagsE.n;
      xNextFlags.z = flagsE.z;
    end
    if (xCondEx && mFlagWriteE[0] && mAluInstrE) begin
      xNextFlags.c = flagsE.c;
      if (arith) xNextFlags.v = flagsE.v;  // Logical ops keep v
    end

    xBranchTaken = mBranchE && xCondEx;
    xMemWrite    = mMemWriteE && xCondEx;
    xRegWrite    = mRegWriteE && xCondEx && !xNoWrite;
    xPcSrc       = mPcSrcE && xCondEx;
    xPending     = dPcSrc || mPcSrcE || mPcSrcM;
  endtask

  task automatic clearModel();
    {mAluSrcE, mAluInstrE, mBranchE, mMemWriteE, mRegWriteE, mMemtoRegE, mPcSrcE} = '0;
    mAluCtrlE   = '0;
    mCondE      = '0;
    mFlagWriteE = '0;
    {mMemWriteM, mRegWriteM, mMemtoRegM, mPcSrcM} = '0;
    {mMemtoRegW, mRegWriteW, mPcSrcW} = '0;
    mFlags = '0;
  endtask

  // Model registers advance with the DUT
  always @(posedge clk) begin
    evalModel();
    if (rst) begin
      clearModel();
    end else begin
      if (flushW) {mMemtoRegW, mRegWriteW, mPcSrcW} = '0;
      else if (!stallW) {mMemtoRegW, mRegWriteW, mPcSrcW} = {mMemtoRegM, mRegWriteM, mPcSrcM};
      if (!stallM) begin
        {mMemWriteM, mRegWriteM, mMemtoRegM, mPcSrcM} =
          {xMemWrite, xRegWrite, mMemtoRegE, xPcSrc};
      end
      if (!stallE) mFlags = xNextFlags;
      if (flushE) begin
        {mAluSrcE, mAluInstrE, mBranchE, mMemWriteE, mRegWriteE, mMemtoRegE, mPcSrcE} = '0;
        mAluCtrlE   = '0;
        mCondE      = '0;
        mFlagWriteE = '0;
      end else if (!stallE) begin
        {mAluSrcE, mAluInstrE, mBranchE, mMemWriteE} = {dAluSrc, dAluInstr, dBranch, dMemWrite};
        {mRegWriteE, mMemtoRegE, mPcSrcE} = {dRegWrite, dMemtoReg, dPcSrc};
        mAluCtrlE   = dAluCtrl;
        mCondE      = instrD[31:28];
        mFlagWriteE = dFlagWrite;
      end
    end
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the test did not finish", cycleCount);
      $display("TB FAILED");
      $finish;
    end
  end

  task automatic checkBit(input string name, input logic exp, input logic got);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("Mismatch at %0d ns: %s expected %b, got %b", $time, name, exp, got);
    end
  endtask

  task automatic checkAluOp(input aluOpT exp, input aluOpT got);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("Mismatch at %0d ns: aluOpE expected %s (%0d), got %s (%0d)",
               $time, exp.name(), exp, got.name(), got);
    end
  endtask

  task automatic checkFlagsSel(input regSrcT expReg, input regSrcT gotReg,
                               input immSrcT expImm, input immSrcT gotImm);
    checkCount += 2;
    if (gotReg !== expReg) begin
      errorCount++;
      $display("Mismatch at %0d ns: regSrcD expected %b, got %b", $time, expReg, gotReg);
    end
    if (gotImm !== expImm) begin
      errorCount++;
      $display("Mismatch at %0d ns: immSrcD expected %b, got %b", $time, expImm, gotImm);
    end
  endtask

  task automatic checkFlags(input flagsT exp, input flagsT got);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("Mismatch at %0d ns: prevFlagsE expected %b, got %b", $time, exp, got);
    end
  endtask

  task automatic compareOutputs();
    checkFlagsSel(dRegSrc, regSrcD, dImmSrc, immSrcD);
    checkBit("pcWrPendingF", xPending, pcWrPendingF);
    checkBit("aluSrcE", mAluSrcE, aluSrcE);
    checkAluOp(xAluOp, aluOpE);
    checkBit("invertBE", xInvB, invertBE);
    checkBit("reverseInputsE", xRev, reverseInputsE);
    checkBit("aluCarryE", xCarry, aluCarryE);
    checkBit("branchTakenE", xBranchTaken, branchTakenE);
    checkBit("memtoRegE", mMemtoRegE, memtoRegE);
    checkBit("memWriteM", mMemWriteM, memWriteM);
    checkBit("regWriteM", mRegWriteM, regWriteM);
    checkBit("memtoRegM", mMemtoRegM, memtoRegM);
    checkBit("memtoRegW", mMemtoRegW, memtoRegW);
    checkBit("regWriteW", mRegWriteW, regWriteW);
    checkBit("pcSrcW", mPcSrcW, pcSrcW);
    checkFlags(mFlags, UUT.execute.prevFlagsE);  // Internal flags register
  endtask

  // Every registered control is cleared by reset
  task automatic checkResetState();
    checkBit("aluSrcE", 1'b0, aluSrcE);
    checkBit("invertBE", 1'b0, invertBE);
    checkBit("reverseInputsE", 1'b0, reverseInputsE);
    checkBit("aluCarryE", 1'b0, aluCarryE);
    checkBit("branchTakenE", 1'b0, branchTakenE);
    checkBit("memtoRegE", 1'b0, memtoRegE);
    checkBit("memWriteM", 1'b0, memWriteM);
    checkBit("regWriteM", 1'b0, regWriteM);
    checkBit("memtoRegM", 1'b0, memtoRegM);
    checkBit("memtoRegW", 1'b0, memtoRegW);
    checkBit("regWriteW", 1'b0, regWriteW);
    checkBit("pcSrcW", 1'b0, pcSrcW);
    checkFlags('0, UUT.execute.prevFlagsE);
  endtask

  task automatic driveRandom();
    logic [31:0] r;
    r      = $urandom;
    instrD = randomInstr();
    flagsE = r[3:0];
    stallE = ($urandom % 10) == 0;  // Each stall about 10%
    stallM = ($urandom % 10) == 0;
    stallW = ($urandom % 10) == 0;
    flushE = ($urandom % 20) == 0;
    flushW = ($urandom % 20) == 0;
  endtask

  initial begin
    void'($urandom(6));
    checkCount = 0;
    errorCount = 0;
    cycleCount = 0;
    instrD = '0;
    flagsE = '0;
    {stallE, stallM, stallW, flushE, flushW} = '0;

    @(negedge rst);
    #1;
    checkResetState();
    evalModel();
    compareOutputs();

    for (int i = 0; i < NUM_INSTRS; i++) begin
      @(negedge clk);
      driveRandom();
      #1;
      evalModel();
      compareOutputs();
    end

    @(negedge clk);
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/clockGen.sv ====
`timescale 1ns/100ps
`default_nettype none

module clockGen (
  output logic clk,
  output logic rst
);
  localparam int HALF_PERIOD = 20;  // 40 ns clock

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Reset spans three rising edges, released on a falling edge
  initial begin
    rst = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== src/aluDecoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module aluDecoder (
  input  wire logic       aluInstr,
  input  wire logic [3:0] aluCtrl,
  input  wire logic [1:0] prevCv,  // {c, v} held in the flags register
  output armCtrlPkg::aluOpT  aluOp,
  output armCtrlPkg::cvUpdT  cvUpdate,
  output logic            invertB,
  output logic            reverseInputs,
  output logic            aluCarry,
  output logic            doNotWrite
);
  import armCtrlPkg::*;

  always_comb begin
    // Address arithmetic for loads, stores and branches
    aluOp         = (aluCtrl == 4'b0010) ? aluSub : aluAdd;
    cvUpdate      = cvNone;
    invertB       = 1'b0;
    reverseInputs = 1'b0;
    aluCarry      = 1'b0;
    doNotWrite    = 1'b0;
    if (aluInstr) begin
      case (aluCtrl)
        4'b0000, 4'b1000:          aluOp = aluAnd;    // AND, TST
        4'b0001, 4'b1001:          aluOp = aluXor;    // EOR, TEQ
        4'b0100, 4'b0101, 4'b1011: aluOp = aluAdd;    // ADD, ADC, CMN
        4'b1100:                   aluOp = aluOr;
        4'b1101, 4'b1111:          aluOp = aluPassB;  // MOV, MVN
        4'b1110:                   aluOp = aluBic;
        default:                   aluOp = aluSub;    // SUB, RSB, SBC, RSC, CMP
      endcase

      cvUpdate = (aluOp inside {aluAdd, aluSub}) ? cvCV : cvCOnly;

      // Compares only touch the flags
      doNotWrite = (aluCtrl[3:2] == 2'b10);

      reverseInputs = (aluCtrl == 4'b0011) || (aluCtrl == 4'b0111);  // RSB, RSC
      invertB       = (aluCtrl == 4'b1110) || (aluCtrl == 4'b1111);  // BIC, MVN

      // ADC, SBC and RSC take the old carry
      aluCarry = (aluCtrl inside {4'b0101, 4'b0110, 4'b0111}) && prevCv[1];
    end
  end

endmodule

`default_nettype wire

// ==== src/armController.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "armCtrl_settings.svh"

module armController (
  input  wire logic                        clk,
  input  wire logic                        rst,
  input  wire logic [`ARMCTRL_INSTR_W-1:0] instrD,
  input  wire armCtrlPkg::flagsT           flagsE,   // ALU result flags
  input  wire logic                        stallE,
  input  wire logic                        stallM,
  input  wire logic                        stallW,
  input  wire logic                        flushE,
  input  wire logic                        flushW,
  output armCtrlPkg::regSrcT               regSrcD,
  output armCtrlPkg::immSrcT               immSrcD,
  output logic                             aluSrcE,
  output armCtrlPkg::aluOpT                aluOpE,
  output logic                             invertBE,
  output logic                             reverseInputsE,
  output logic                             aluCarryE,
  output logic                             branchTakenE,
  output logic                             memtoRegE,
  output logic                             memWriteM,
  output logic                             regWriteM,
  output logic                             memtoRegM,
  output logic                             memtoRegW,
  output logic                             regWriteW,
  output logic                             pcSrcW,
  output logic                             pcWrPendingF
);

  // Raw Execute controls, before condition gating
  logic [3:0] aluCtrlE;
  logic       aluInstrE;
  logic [1:0] flagWriteE;
  logic       branchE;
  logic       memWriteE;
  logic       regWriteE;
  logic       pcSrcE;
  logic [3:0] condE;
  logic       pcSrcD;
  logic       pcSrcM;

  decodeStage decode (
    .clk, .rst, .instrD, .stallE, .flushE, .regSrcD, .immSrcD, .pcSrcD,
    .aluSrcE, .aluCtrlE, .aluInstrE, .flagWriteE, .branchE, .memWriteE,
    .regWriteE, .memtoRegE, .pcSrcE, .condE
  );

  executeStage execute (
    .clk, .rst, .stallE, .stallM, .flagsE, .aluCtrlE, .aluInstrE, .flagWriteE,
    .branchE, .memWriteE, .regWriteE, .memtoRegE, .pcSrcE, .condE,
    .aluOpE, .invertBE, .reverseInputsE, .aluCarryE, .branchTakenE,
    .memWriteM, .regWriteM, .memtoRegM, .pcSrcM
  );

  memWbStage memWb (
    .clk, .rst, .stallW, .flushW, .memtoRegM, .regWriteM, .pcSrcD, .pcSrcE, .pcSrcM,
    .memtoRegW, .regWriteW, .pcSrcW, .pcWrPendingF
  );

endmodule

`default_nettype wire

// ==== src/armCtrlPkg.sv ====
`default_nettype none

package armCtrlPkg;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  typedef enum logic [2:0] {
    aluAnd   = 3'd0,
    aluOr    = 3'd1,
    aluXor   = 3'd2,
    aluAdd   = 3'd3,
    aluSub   = 3'd4,
    aluPassB = 3'd5,
    aluBic   = 3'd6   // And with inverted B
  } aluOpT;

  // Bit 1 lets c update, bit 0 lets v update
  typedef enum logic [2:0] {
    cvNone  = 3'b000,
    cvCOnly = 3'b010,  // Logical ops, c from shifter
    cvCV    = 3'b011   // Arithmetic ops
  } cvUpdT;

  typedef enum logic [1:0] {
    regSrcNormal = 2'b00,
    regSrcBranch = 2'b01,  // Port 1 reads the PC
    regSrcStore  = 2'b10   // Port 2 reads Rd for STR
  } regSrcT;

  typedef enum logic [1:0] {
    immDp     = 2'b00,  // 8-bit rotated immediate
    immMem    = 2'b01,  // 12-bit offset
    immBranch = 2'b10   // 24-bit word offset
  } immSrcT;

endpackage

`default_nettype wire

// ==== src/armCtrl_settings.svh ====
`ifndef ARMCTRL_SETTINGS_SVH
`define ARMCTRL_SETTINGS_SVH

// One instruction word
`define ARMCTRL_INSTR_W 32

// Condition code for "always"
`define ARMCTRL_COND_AL 4'hE

`define ARMCTRL_PC_REG 4'd15  // R15 is the PC

`endif

// ==== src/condCheck.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "armCtrl_settings.svh"

module condCheck (
  input  wire logic [3:0]        cond,
  input  wire armCtrlPkg::flagsT prevFlags,
  input  wire armCtrlPkg::flagsT aluFlags,
  input  wire logic [1:0]        flagWrite,  // {nz, cv}
  output logic                   condEx,
  output armCtrlPkg::flagsT      nextFlags
);

  logic ge;

  assign ge = (prevFlags.n == prevFlags.v);  // Signed greater or equal

  always_comb begin
    case (cond)
      4'h0:             condEx = prevFlags.z;                 // EQ
      4'h1:             condEx = !prevFlags.z;                // NE
      4'h2:             condEx = prevFlags.c;                 // CS
      4'h3:             condEx = !prevFlags.c;                // CC
      4'h4:             condEx = prevFlags.n;                 // MI
      4'h5:             condEx = !prevFlags.n;                // PL
      4'h6:             condEx = prevFlags.v;                 // VS
      4'h7:             condEx = !prevFlags.v;                // VC
      4'h8:             condEx = prevFlags.c && !prevFlags.z;  // HI
      4'h9:             condEx = !prevFlags.c || prevFlags.z;  // LS
      4'hA:             condEx = ge;
      4'hB:             condEx = !ge;
      4'hC:             condEx = !prevFlags.z && ge;          // GT
      4'hD:             condEx = prevFlags.z || !ge;          // LE
      `ARMCTRL_COND_AL: condEx = 1'b1;
      default:          condEx = 1'b0;  // 4'hF is outside the subset
    endcase
  end

  always_comb begin
    nextFlags = prevFlags;
    if (condEx && flagWrite[1]) begin
      nextFlags.n = aluFlags.n;
      nextFlags.z = aluFlags.z;
    end
    if (condEx && flagWrite[0]) begin
      nextFlags.c = aluFlags.c;
      nextFlags.v = aluFlags.v;
    end
  end

endmodule

`default_nettype wire

// ==== src/decodeStage.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "armCtrl_settings.svh"

module decodeStage (
  input  wire logic                        clk,
  input  wire logic                        rst,
  input  wire logic [`ARMCTRL_INSTR_W-1:0] instrD,
  input  wire logic                        stallE,
  input  wire logic                        flushE,
  output armCtrlPkg::regSrcT               regSrcD,
  output armCtrlPkg::immSrcT               immSrcD,
  output logic                             pcSrcD,
  output logic                             aluSrcE,
  output logic [3:0]                       aluCtrlE,
  output logic                             aluInstrE,
  output logic [1:0]                       flagWriteE,
  output logic                             branchE,
  output logic                             memWriteE,
  output logic                             regWriteE,
  output logic                             memtoRegE,
  output logic                             pcSrcE,
  output logic [3:0]                       condE
);
  import armCtrlPkg::*;

  logic       aluSrcD;
  logic [3:0] aluCtrlD;
  logic       aluInstrD;
  logic [1:0] flagWriteD;
  logic       branchD;
  logic       memWriteD;
  logic       regWriteD;
  logic       memtoRegD;

  always_comb begin
    regSrcD    = regSrcNormal;
    immSrcD    = immDp;
    aluSrcD    = 1'b0;
    aluCtrlD   = 4'b0100;  // Add unless told otherwise
    aluInstrD  = 1'b0;
    flagWriteD = 2'b00;
    branchD    = 1'b0;
    memWriteD  = 1'b0;
    regWriteD  = 1'b0;
    memtoRegD  = 1'b0;
    case (instrD[27:26])
      2'b00: begin  // Data processing, bit 25 picks immediate
        aluSrcD    = instrD[25];
        aluCtrlD   = instrD[24:21];
        aluInstrD  = 1'b1;
        flagWriteD = {2{instrD[20]}};  // S bit
        regWriteD  = 1'b1;
      end
      2'b01: begin
        immSrcD  = immMem;
        aluSrcD  = 1'b1;
        aluCtrlD = instrD[23] ? 4'b0100 : 4'b0010;  // U bit, add or subtract
        if (instrD[20]) begin  // LDR
          memtoRegD = 1'b1;
          regWriteD = 1'b1;
        end else begin
          memWriteD = 1'b1;
          regSrcD   = regSrcStore;
        end
      end
      2'b10: begin
        regSrcD = regSrcBranch;
        immSrcD = immBranch;
        aluSrcD = 1'b1;
        branchD = 1'b1;
      end
      default: ;  // Unimplemented class decodes as a no-op
    endcase
  end

  assign pcSrcD = (regWriteD && instrD[15:12] == `ARMCTRL_PC_REG) || branchD;

  always_ff @(posedge clk) begin
    if (rst || flushE) begin
      {aluSrcE, aluCtrlE, aluInstrE, flagWriteE, branchE} <= '0;
      {memWriteE, regWriteE, memtoRegE, pcSrcE, condE} <= '0;
    end else if (!stallE) begin
      {aluSrcE, aluCtrlE, aluInstrE, flagWriteE, branchE} <=
        {aluSrcD, aluCtrlD, aluInstrD, flagWriteD, branchD};
      {memWriteE, regWriteE, memtoRegE, pcSrcE} <= {memWriteD, regWriteD, memtoRegD, pcSrcD};
      condE <= instrD[31:28];
    end
  end

  // Nothing outside the subset may reach Execute
  assert property (@(posedge clk) disable iff (rst)
    (!stallE && !flushE) |-> instrD[27:26] != 2'b11)
    else $error("Unimplemented instruction class in Decode");

endmodule

`default_nettype wire

// ==== src/executeStage.sv ====
`timescale 1ns/100ps
`default_nettype none

module executeStage (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              stallE,
  input  wire logic              stallM,
  input  wire armCtrlPkg::flagsT flagsE,
  input  wire logic [3:0]        aluCtrlE,
  input  wire logic              aluInstrE,
  input  wire logic [1:0]        flagWriteE,
  input  wire logic              branchE,
  input  wire logic              memWriteE,
  input  wire logic              regWriteE,
  input  wire logic              memtoRegE,
  input  wire logic              pcSrcE,
  input  wire logic [3:0]        condE,
  output armCtrlPkg::aluOpT      aluOpE,
  output logic                   invertBE,
  output logic                   reverseInputsE,
  output logic                   aluCarryE,
  output logic                   branchTakenE,
  output logic                   memWriteM,
  output logic                   regWriteM,
  output logic                   memtoRegM,
  output logic                   pcSrcM
);
  import armCtrlPkg::*;

  flagsT      prevFlagsE;
  flagsT      nextFlagsE;
  flagsT      aluFlagsE;
  cvUpdT      cvUpdateE;
  logic       condExE;
  logic       doNotWriteE;
  logic [1:0] flagWriteSelE;
  logic       memWriteGatedE;
  logic       regWriteGatedE;
  logic       pcSrcGatedE;

  aluDecoder aluDec (
    .aluInstr(aluInstrE), .aluCtrl(aluCtrlE), .prevCv({prevFlagsE.c, prevFlagsE.v}),
    .aluOp(aluOpE), .cvUpdate(cvUpdateE), .invertB(invertBE),
    .reverseInputs(reverseInputsE), .aluCarry(aluCarryE), .doNotWrite(doNotWriteE)
  );

  // Logical ops keep v, so only the allowed flags come from the ALU
  assign aluFlagsE.n = flagsE.n;
  assign aluFlagsE.z = flagsE.z;
  assign aluFlagsE.c = flagsE.c;
  assign aluFlagsE.v = (cvUpdateE == cvCV) ? flagsE.v : prevFlagsE.v;
  assign flagWriteSelE = {flagWriteE[1], flagWriteE[0] && (cvUpdateE != cvNone)};

  condCheck cond (
    .cond(condE), .prevFlags(prevFlagsE), .aluFlags(aluFlagsE),
    .flagWrite(flagWriteSelE), .condEx(condExE), .nextFlags(nextFlagsE)
  );

  always_ff @(posedge clk) begin
    if (rst) prevFlagsE <= '0;
    else if (!stallE) prevFlagsE <= nextFlagsE;  // Held instruction writes once
  end

  assign branchTakenE   = branchE && condExE;
  assign memWriteGatedE = memWriteE && condExE;
  assign regWriteGatedE = regWriteE && condExE && !doNotWriteE;
  assign pcSrcGatedE    = pcSrcE && condExE;

  always_ff @(posedge clk) begin
    if (rst) begin
      {memWriteM, regWriteM, memtoRegM, pcSrcM} <= '0;
    end else if (!stallM) begin
      {memWriteM, regWriteM, memtoRegM, pcSrcM} <=
        {memWriteGatedE, regWriteGatedE, memtoRegE, pcSrcGatedE};
    end
  end

  // A taken branch must redirect the PC from the Memory stage
  assert property (@(posedge clk) disable iff (rst)
    (branchTakenE && !stallM) |=> pcSrcM)
    else $error("Taken branch lost between Execute and Memory");

endmodule

`default_nettype wire

// ==== src/memWbStage.sv ====
`timescale 1ns/100ps
`default_nettype none

module memWbStage (
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic stallW,
  input  wire logic flushW,
  input  wire logic memtoRegM,
  input  wire logic regWriteM,
  input  wire logic pcSrcD,
  input  wire logic pcSrcE,
  input  wire logic pcSrcM,
  output logic      memtoRegW,
  output logic      regWriteW,
  output logic      pcSrcW,
  output logic      pcWrPendingF
);

  always_ff @(posedge clk) begin
    if (rst || flushW) begin
      memtoRegW <= 1'b0;
      regWriteW <= 1'b0;
      pcSrcW    <= 1'b0;
    end else if (!stallW) begin
      memtoRegW <= memtoRegM;
      regWriteW <= regWriteM;
      pcSrcW    <= pcSrcM;
    end
  end

  // Fetch waits while any older instruction may still write R15
  assign pcWrPendingF = pcSrcD || pcSrcE || pcSrcM;

  assert property (@(posedge clk) disable iff (rst) !$isunknown(regWriteW))
    else $error("regWriteW unknown after reset");

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+src
src/armCtrlPkg.sv
src/aluDecoder.sv
src/condCheck.sv
src/decodeStage.sv
src/executeStage.sv
src/memWbStage.sv
src/armController.sv
bench/clockGen.sv
bench/armControllerTb.sv
